/* hdl/thread_pkg.sv */
package thread_pkg;

	// Hardware threads sharing the fetch path
	localparam int N_THREADS = 4;

	// Thread index
	typedef logic [$clog2(N_THREADS)-1:0] thread_t;

	// One runnable bit per thread
	typedef logic [N_THREADS-1:0] thread_mask_t;

endpackage

/* hdl/cpu_pkg.sv */
package cpu_pkg;

	// Instruction memory geometry
	localparam int IADDR_W  = 6;
	localparam int INSTR_W  = 16;
	localparam int OPCODE_W = 3;

	// Prefetch buffer between fetch and execute
	localparam int FIFO_DEPTH = 4;

	// Hex image loaded into the instruction memory
	localparam string PROGRAM_FILE = "program.mem";

	typedef logic [IADDR_W-1:0] iaddr_t;
	typedef logic [INSTR_W-1:0] instr_t;

	// Opcode sits in the top OPCODE_W bits, values 4..7 are illegal
	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP   = 3'd0,
		OP_JMP   = 3'd1,
		OP_YIELD = 3'd2,
		OP_HALT  = 3'd3
	} opcode_e;

	// Kind of thread switch sent from execute back to fetch
	typedef enum logic [1:0] {
		SW_JMP   = 2'd1,
		SW_YIELD = 2'd2,
		SW_HALT  = 2'd3
	} sw_kind_e;

	// One prefetched instruction with its origin
	typedef struct packed {
		instr_t             instr;
		iaddr_t             addr;
		thread_pkg::thread_t thread;
	} fetch_item_t;

endpackage

/* hdl/instr_stream_if.sv */
`timescale 1ns/1ps

interface instr_stream_if import cpu_pkg::*; ();

	// Item handshake, transfer when both are high at the clock edge
	logic        valid;
	logic        ready;
	fetch_item_t data;

	// Producer side
	modport source (
		output valid,
		output data,
		input  ready
	);

	// Consumer side
	modport sink (
		input  valid,
		input  data,
		output ready
	);

endinterface

/* hdl/exec_ctrl_if.sv */
`timescale 1ns/1ps

interface exec_ctrl_if import cpu_pkg::*; ();

	// Switch request, held by the executor until sw_ready
	logic     sw_valid;
	logic     sw_ready;
	sw_kind_e sw_kind;
	iaddr_t   sw_target;
	// Strobe for every instruction taken by the executor
	logic     executed;

	modport executor (output sw_valid, sw_kind, sw_target, executed, input sw_ready);
	modport fetch (input sw_valid, sw_kind, sw_target, executed, output sw_ready);
	modport monitor (input sw_valid, sw_ready, sw_kind, sw_target, executed);

endinterface

/* hdl/thread_scheduler.sv */
`timescale 1ns/1ps

module thread_scheduler import cpu_pkg::*; import thread_pkg::*; (
	input  logic          CLK,
	input  logic          rst_n,
	// Thread start channel
	input  logic          start_valid,
	output logic          start_ready,
	input  thread_t       start_thread,
	input  iaddr_t        start_entry,
	// Switch requests, observed only
	exec_ctrl_if.monitor  ctrl,
	output thread_t       thread_num,
	output thread_t       thread_num_ahead,
	output logic          reload,
	// Pointer memory initialisation toward fetch
	output logic          init_wr,
	output thread_t       init_thread,
	output iaddr_t        init_addr,
	output logic          idle
);

	thread_mask_t runnable;
	logic         sw_fire;
	logic         start_fire;
	logic         others_left;

	assign sw_fire = ctrl.sw_valid & ctrl.sw_ready;

	// A thread can be started only while it is not runnable
	// Starts wait out the cycle of a switch, it owns the pointer memory port
	assign start_ready = ~runnable[start_thread] & ~sw_fire;
	assign start_fire  = start_valid & start_ready;

	assign init_wr     = start_fire;
	assign init_thread = start_thread;
	assign init_addr   = start_entry;

	assign idle = (runnable == '0);

	// Threads other than the current one still runnable
	assign others_left = ((runnable & ~(thread_mask_t'(1) << thread_num)) != '0);

	// *********************************************************************
	// Look-ahead selection
	// *********************************************************************
	always_comb begin
		thread_t cand;
		cand = thread_num;
		thread_num_ahead = thread_num;
		// Walk backwards so the closest runnable successor wins
		// i == N_THREADS wraps onto the current thread itself
		for (int i = N_THREADS; i >= 1; i--) begin
			cand = thread_t'(thread_num + i);
			if (runnable[cand])
				thread_num_ahead = cand;
		end
	end

	// *********************************************************************
	// Runnable mask, current thread, reload request
	// *********************************************************************
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			runnable   <= '0;
			thread_num <= '0;
			reload     <= 1'b0;
		end else begin
			// Halt drops the current thread from the mask
			if (sw_fire && ctrl.sw_kind == SW_HALT)
				runnable[thread_num] <= 1'b0;
			if (start_fire)
				runnable[start_thread] <= 1'b1;

			// Reload needs a thread to go to, none left after the last halt
			reload <= (sw_fire && (ctrl.sw_kind != SW_HALT || others_left))
				|| (start_fire && idle);

			// Move on while fetch loads the pointers of that thread
			if (reload)
				thread_num <= thread_num_ahead;
		end
	end

endmodule

/* hdl/instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch import cpu_pkg::*; import thread_pkg::*; (
	input  logic          CLK,
	input  logic          rst_n,
	input  thread_t       thread_num,
	input  thread_t       thread_num_ahead,
	input  logic          reload,
	input  logic          init_wr,
	input  thread_t       init_thread,
	input  iaddr_t        init_addr,
	exec_ctrl_if.fetch    ctrl,
	instr_stream_if.source out
);

	// Saved pointer per thread, next address to run
	iaddr_t ptr_mem [N_THREADS];
	// Next address to read
	iaddr_t cur_ptr;
	// Address of the last instruction taken by the executor
	iaddr_t eff_ptr;
	iaddr_t save_ptr;

	instr_t instr_mem [2**IADDR_W];

	logic        running;
	logic        item_valid;
	fetch_item_t item_q;
	logic        sw_fire;
	logic        issue;

	initial
		$readmemh(PROGRAM_FILE, instr_mem);

	// Busy while the pointers of the next thread load
	assign ctrl.sw_ready = ~reload;
	assign sw_fire = ctrl.sw_valid & ctrl.sw_ready;

	// Read when running and the output slot is free or leaving
	assign issue = running & ~sw_fire & (~item_valid | out.ready);

	// JMP resumes at its target, YIELD just past itself
	assign save_ptr = (ctrl.sw_kind == SW_JMP) ? ctrl.sw_target : eff_ptr + 1'b1;

	// *********************************************************************
	// Pointer memory
	// *********************************************************************
	// Start and switch never share a cycle
	always_ff @(posedge CLK) begin
		if (init_wr)
			ptr_mem[init_thread] <= init_addr;
		else if (sw_fire && ctrl.sw_kind != SW_HALT)
			ptr_mem[thread_num] <= save_ptr;
	end

	// *********************************************************************
	// Current and effective pointers, fetch control
	// *********************************************************************
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			running    <= 1'b0;
			item_valid <= 1'b0;
			cur_ptr    <= '0;
			eff_ptr    <= '0;
		end else if (reload) begin
			running    <= 1'b1;
			item_valid <= 1'b0;
			cur_ptr    <= ptr_mem[thread_num_ahead];
			// One behind, nothing of this thread retired yet
			eff_ptr    <= ptr_mem[thread_num_ahead] - 1'b1;
		end else if (sw_fire) begin
			// Drop the read in flight and wait for the reload
			running    <= 1'b0;
			item_valid <= 1'b0;
		end else begin
			if (issue)
				cur_ptr <= cur_ptr + 1'b1;
			if (ctrl.executed)
				eff_ptr <= eff_ptr + 1'b1;
			// Item stays put under back-pressure
			item_valid <= issue | (item_valid & ~out.ready);
		end
	end

	// *********************************************************************
	// Instruction memory, registered read
	// *********************************************************************
	always_ff @(posedge CLK) begin
		if (issue) begin
			item_q.instr  <= instr_mem[cur_ptr];
			item_q.addr   <= cur_ptr;
			item_q.thread <= thread_num;
		end
	end

	assign out.valid = item_valid;
	assign out.data  = item_q;

endmodule

/* hdl/instr_fifo.sv */
`timescale 1ns/1ps

module instr_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH = 2
) (
	input  logic           CLK,
	input  logic           rst_n,
	input  logic           flush,
	instr_stream_if.sink   in,
	instr_stream_if.source out
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Full drops ready, empty drops valid
	assign in.ready  = (count != CNT_W'(DEPTH));
	assign out.valid = (count != '0);
	assign out.data  = mem[rd_ptr];

	assign push = in.valid & in.ready;
	assign pop  = out.valid & out.ready;

	// Storage, no reset
	always_ff @(posedge CLK) begin
		if (push)
			mem[wr_ptr] <= in.data;
	end

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

/* hdl/instr_executor.sv */
`timescale 1ns/1ps

module instr_executor import cpu_pkg::*; import thread_pkg::*; (
	input  logic          CLK,
	input  logic          rst_n,
	instr_stream_if.sink  in,
	exec_ctrl_if.executor ctrl,
	output logic          retire_valid,
	output thread_t       retire_thread,
	output iaddr_t        retire_addr,
	output instr_t        retire_instr,
	output logic          err
);

	opcode_e op;
	logic    pop;

	assign op = opcode_e'(in.data.instr[INSTR_W-1 -: OPCODE_W]);

	// Take everything until a switch is pending
	assign in.ready = ~ctrl.sw_valid;
	assign pop      = in.valid & in.ready;

	assign ctrl.executed = pop;

	// *********************************************************************
	// Retire and switch request
	// *********************************************************************
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			retire_valid  <= 1'b0;
			ctrl.sw_valid <= 1'b0;
			err           <= 1'b0;
		end else begin
			retire_valid <= pop;
			if (ctrl.sw_valid && ctrl.sw_ready)
				ctrl.sw_valid <= 1'b0;
			if (pop) begin
				case (op)
					OP_NOP: ;
					OP_JMP, OP_YIELD, OP_HALT:
						ctrl.sw_valid <= 1'b1;
					// Illegal opcode, sticky error and stop the thread
					default: begin
						err           <= 1'b1;
						ctrl.sw_valid <= 1'b1;
					end
				endcase
			end
		end
	end

	// Payload registers
	always_ff @(posedge CLK) begin
		if (pop) begin
			retire_thread <= in.data.thread;
			retire_addr   <= in.data.addr;
			retire_instr  <= in.data.instr;
			case (op)
				OP_JMP:   ctrl.sw_kind <= SW_JMP;
				OP_YIELD: ctrl.sw_kind <= SW_YIELD;
				default:  ctrl.sw_kind <= SW_HALT;
			endcase
			// Jump target in the low bits, else the own address
			ctrl.sw_target <= (op == OP_JMP) ? in.data.instr[IADDR_W-1:0] : in.data.addr;
		end
	end

endmodule

/* hdl/thread_fetch_top.sv */
`timescale 1ns/1ps

module thread_fetch_top import cpu_pkg::*; import thread_pkg::*; (
	input  logic    CLK,
	input  logic    rst_n,
	// Start channel
	input  logic    start_valid,
	output logic    start_ready,
	input  thread_t start_thread,
	input  iaddr_t  start_entry,
	// Retire strobe and its item
	output logic    retire_valid,
	output thread_t retire_thread,
	output iaddr_t  retire_addr,
	output instr_t  retire_instr,
	// Status
	output logic    idle,
	output logic    err
);

	thread_t thread_num;
	thread_t thread_num_ahead;
	logic    reload;
	logic    init_wr;
	thread_t init_thread;
	iaddr_t  init_addr;
	logic    flush;

	exec_ctrl_if    ctrl_bus ();
	instr_stream_if fetch_stream ();
	instr_stream_if exec_stream ();

	// Prefetched work is stale once a switch is accepted
	assign flush = ctrl_bus.sw_valid & ctrl_bus.sw_ready;

	thread_scheduler u_scheduler (
		.CLK, .rst_n,
		.start_valid, .start_ready, .start_thread, .start_entry,
		.ctrl (ctrl_bus.monitor),
		.thread_num, .thread_num_ahead, .reload,
		.init_wr, .init_thread, .init_addr,
		.idle
	);

	instruction_fetch u_fetch (
		.CLK, .rst_n,
		.thread_num, .thread_num_ahead, .reload,
		.init_wr, .init_thread, .init_addr,
		.ctrl (ctrl_bus.fetch),
		.out  (fetch_stream.source)
	);

	instr_fifo #(.payload_t(fetch_item_t), .DEPTH(FIFO_DEPTH)) u_fifo (
		.CLK, .rst_n, .flush,
		.in  (fetch_stream.sink),
		.out (exec_stream.source)
	);

	instr_executor u_executor (
		.CLK, .rst_n,
		.in   (exec_stream.sink),
		.ctrl (ctrl_bus.executor),
		.retire_valid, .retire_thread, .retire_addr, .retire_instr,
		.err
	);

endmodule

/* verification/thread_fetch_tb.sv */
`timescale 1ns/1ps

module thread_fetch_tb import cpu_pkg::*; import thread_pkg::*; ();

	localparam int N_STARTS = 12;
	// 40 cycles per program word for every start
	localparam int TIMEOUT  = 40 * (2**IADDR_W) * N_STARTS;

	logic    CLK;
	logic    rst_n;
	logic    start_valid;
	logic    start_ready;
	thread_t start_thread;
	iaddr_t  start_entry;
	logic    retire_valid;
	thread_t retire_thread;
	iaddr_t  retire_addr;
	instr_t  retire_instr;
	logic    idle;
	logic    err;

	// Reference model state
	instr_t       prog [2**IADDR_W];
	iaddr_t       exp_ptr [N_THREADS];
	thread_mask_t model_run;
	logic         err_exp;
	logic         next_valid;
	thread_t      next_thread;
	logic         start_seen;
	// Legal program entry points
	iaddr_t       entries [4] = '{6'd0, 6'd5, 6'd14, 6'd16};

	logic [31:0] lfsr;
	int          errors;
	int          retires;
	int          starts;
	int          cycles;

	thread_fetch_top uut (.*);

	always #4 CLK = ~CLK;

	// *********************************************************************
	// Stimulus helpers
	// *********************************************************************
	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Start a thread and wait until the start channel accepts it
	task automatic launch_thread(input thread_t t, input iaddr_t e);
		logic accepted;
		accepted = 1'b0;
		@(negedge CLK);
		start_valid  = 1'b1;
		start_thread = t;
		start_entry  = e;
		while (!accepted) begin
			@(posedge CLK);
			accepted = start_ready;
		end
		assert (!model_run[t])
		else begin
			errors++;
			$display("start accepted for thread %0d while it is still runnable", t);
		end
		model_run[t] = 1'b1;
		exp_ptr[t]   = e;
		start_seen   = 1'b1;
		starts++;
		@(negedge CLK);
		start_valid = 1'b0;
	endtask

	task automatic wait_all_halted();
		do
			@(negedge CLK);
		while (!idle);
		assert (model_run == '0)
		else begin
			errors++;
			$display("idle high while threads are still runnable in the model");
		end
	endtask

	// *********************************************************************
	// Retire checks and reference model
	// *********************************************************************
	always @(negedge CLK) begin
		logic [OPCODE_W-1:0] op;
		instr_t              exp_instr;
		if (rst_n && retire_valid) begin
			retires++;
			// Model instruction of this thread drives the next expected pointer
			exp_instr = prog[exp_ptr[retire_thread]];
			op = exp_instr[INSTR_W-1 -: OPCODE_W];
			assert (model_run[retire_thread])
			else begin
				errors++;
				$display("retire from thread %0d which is not runnable", retire_thread);
			end
			assert (retire_instr == prog[retire_addr])
			else begin
				errors++;
				$display("mismatch retire_instr: got %h expected %h",
					retire_instr, prog[retire_addr]);
			end
			assert (retire_addr == exp_ptr[retire_thread])
			else begin
				errors++;
				$display("mismatch retire_addr: got %h expected %h",
					retire_addr, exp_ptr[retire_thread]);
			end
			// Thread order after a switch unless a start changed the mask
			if (next_valid && !start_seen) begin
				assert (retire_thread == next_thread)
				else begin
					errors++;
					$display("mismatch retire_thread: got %h expected %h",
						retire_thread, next_thread);
				end
			end
			next_valid = 1'b0;
			assert (!idle)
			else begin
				errors++;
				$display("idle is high while an instruction retires");
			end
			case (op)
				3'd0: exp_ptr[retire_thread] = exp_ptr[retire_thread] + 1'b1;
				3'd1: exp_ptr[retire_thread] = exp_instr[IADDR_W-1:0];
				3'd2: exp_ptr[retire_thread] = exp_ptr[retire_thread] + 1'b1;
				default: begin
					// HALT or illegal opcode takes the thread out of the mask
					if (op > 3'd3)
						err_exp = 1'b1;
					model_run[retire_thread] = 1'b0;
				end
			endcase
			if (op != 3'd0) begin
				start_seen = 1'b0;
				// First runnable thread after this one with itself last
				for (int i = N_THREADS; i >= 1; i--) begin
					if (model_run[thread_t'(retire_thread + i)]) begin
						next_valid  = 1'b1;
						next_thread = thread_t'(retire_thread + i);
					end
				end
			end
		end
		if (rst_n) begin
			assert (err == err_exp)
			else begin
				errors++;
				$display("mismatch err: got %h expected %h", err, err_exp);
			end
		end
	end

	// Run limit
	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, errors: %0d retires: %0d starts: %0d",
				cycles, errors, retires, starts);
			$display("Simulation failed");
			$finish;
		end
	end

	// *********************************************************************
	// Main sequence
	// *********************************************************************
	initial begin
		logic [31:0] v;
		thread_t     t;
		CLK          = 1'b0;
		rst_n        = 1'b0;
		start_valid  = 1'b0;
		start_thread = '0;
		start_entry  = '0;
		model_run    = '0;
		err_exp      = 1'b0;
		next_valid   = 1'b0;
		next_thread  = '0;
		start_seen   = 1'b0;
		errors       = 0;
		retires      = 0;
		starts       = 0;
		cycles       = 0;
		lfsr         = 32'h8927_4d19;
		for (int i = 0; i < N_THREADS; i++)
			exp_ptr[i] = '0;
		$readmemh(PROGRAM_FILE, prog);

		repeat (10) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;

		// Quiet state after reset
		@(negedge CLK);
		assert (!retire_valid && !err && idle)
		else begin
			errors++;
			$display("outputs after reset are not retire_valid=0 err=0 idle=1");
		end
		for (int i = 0; i < N_THREADS; i++) begin
			start_thread = thread_t'(i);
			#1;
			assert (start_ready)
			else begin
				errors++;
				$display("start_ready low for thread %0d after reset", i);
			end
		end

		// One thread alone and then overlapping random starts
		launch_thread(2'd0, entries[0]);
		wait_all_halted();
		for (int k = 1; k < N_STARTS; k++) begin
			v = lfsr_bits(2);
			t = thread_t'(v[1:0]);
			v = lfsr_bits(2);
			launch_thread(t, entries[v[1:0]]);
		end
		wait_all_halted();
		repeat (5) @(negedge CLK);

		$display("errors: %0d retires: %0d starts: %0d cycles: %0d",
			errors, retires, starts, cycles);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* program.mem */
// One 16-bit instruction word per address, 0x00 to 0x3F, eight words per line
// Opcode in bits 15:13 (0 NOP, 1 JMP, 2 YIELD, 3 HALT, 4..7 illegal), jump target in bits 5:0
0000 0000 4000 0000 6000 0000 200A 6000
6000 6000 0000 4000 0000 6000 0000 8000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 4000 0000 0000 0000
0000 0000 0000 0000 6000 6000 6000 6000
6000 6000 6000 6000 6000 6000 6000 6000
6000 6000 6000 6000 6000 6000 6000 6000
6000 6000 6000 6000 6000 6000 6000 6000

/* thread_fetch_top.f */
hdl/thread_pkg.sv
hdl/cpu_pkg.sv
hdl/instr_stream_if.sv
hdl/exec_ctrl_if.sv
hdl/thread_scheduler.sv
hdl/instruction_fetch.sv
hdl/instr_fifo.sv
hdl/instr_executor.sv
hdl/thread_fetch_top.sv
verification/thread_fetch_tb.sv

/* Bender.yml */
package:
  name: thread_fetch

sources:
  - hdl/thread_pkg.sv
  - hdl/cpu_pkg.sv
  - hdl/instr_stream_if.sv
  - hdl/exec_ctrl_if.sv
  - hdl/thread_scheduler.sv
  - hdl/instruction_fetch.sv
  - hdl/instr_fifo.sv
  - hdl/instr_executor.sv
  - hdl/thread_fetch_top.sv
  - target: test
    files:
      - verification/thread_fetch_tb.sv
